// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_soc_periph
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
hw/periph_pkg.sv
hw/apb_if.sv
hw/apb_periph_decoder.sv
hw/periph_soc_ctrl.sv
hw/periph_gpio.sv
hw/periph_timer.sv
hw/periph_event_map.sv
hw/soc_periph_top.sv
dv/tb_soc_periph.sv

// File: dv/tb_soc_periph.sv
// Testbench for the SoC peripheral subsystem
// Directed tests over the APB port for SoC control, GPIO, the timer,
// the reference clock events and the unmapped-region error response

`timescale 1ns/1ps

module tb_soc_periph;
    import periph_pkg::*;

    localparam int unsigned NGPIO      = 8;
    localparam apb_data_t   BOOT_ADDR  = 32'h1C00_8080;
    localparam logic [31:0] GPIO_MASK  = 32'hFFFF_FFFF >> (32 - NGPIO);
    // All tests together take well under 1000 cycles
    localparam int          MAX_CYCLES = 5000;

    logic                  clk;
    logic                  rst_n;
    apb_addr_t             paddr;
    apb_data_t             pwdata;
    logic                  pwrite;
    logic                  psel;
    logic                  penable;
    apb_data_t             prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  slow_clk;
    logic                  fetch_en_valid;
    logic                  fetch_en;
    logic [7:0]            jtag_in;
    logic [7:0]            jtag_out;
    logic [NGPIO-1:0]      gpio_in;
    logic [NGPIO-1:0]      gpio_out;
    logic [NGPIO-1:0]      gpio_dir;
    apb_data_t             bootaddr;
    logic                  fetchen;
    logic [FC_EVENT_W-1:0] fc_events;

    int checks;
    int errors;
    int cycle_cnt;
    int tmr_cnt;
    int ref_cnt;
    int gpio_cnt;
    int tmr_stamps[$];

    soc_periph_top #(
        .NGPIO             ( NGPIO     ),
        .BOOT_ADDR_DEFAULT ( BOOT_ADDR )
    ) dut0 (
        .clk_i               ( clk            ),
        .rst_ni              ( rst_n          ),
        .paddr_i             ( paddr          ),
        .pwdata_i            ( pwdata         ),
        .pwrite_i            ( pwrite         ),
        .psel_i              ( psel           ),
        .penable_i           ( penable        ),
        .prdata_o            ( prdata         ),
        .pready_o            ( pready         ),
        .pslverr_o           ( pslverr        ),
        .slow_clk_i          ( slow_clk       ),
        .fc_fetch_en_valid_i ( fetch_en_valid ),
        .fc_fetch_en_i       ( fetch_en       ),
        .soc_jtag_reg_i      ( jtag_in        ),
        .soc_jtag_reg_o      ( jtag_out       ),
        .gpio_i              ( gpio_in        ),
        .gpio_out_o          ( gpio_out       ),
        .gpio_dir_o          ( gpio_dir       ),
        .fc_bootaddr_o       ( bootaddr       ),
        .fc_fetchen_o        ( fetchen        ),
        .fc_events_o         ( fc_events      )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog, also the cycle count used for event time stamps
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

    // Event monitor, sampled mid-cycle where the event word is stable
    always @(negedge clk) begin
        if (fc_events[EVT_TIMER_LO]) begin
            tmr_cnt++;
            tmr_stamps.push_back(cycle_cnt);
        end
        if (fc_events[EVT_REF_CLK]) ref_cnt++;
        if (fc_events[EVT_GPIO]) gpio_cnt++;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic apb_addr_t reg_addr(input region_e region, input logic [7:0] offset);
        return {region, offset};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = write;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, output logic err);
        apb_data_t unused;
        apb_xfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
        apb_xfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_timer_pulses(input int count, input int max_wait);
        int waited;
        waited = 0;
        while (tmr_stamps.size() < count && waited < max_wait) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (tmr_stamps.size() < count) begin
            errors++;
            $display("Error at %0t: saw %0d timer events, expected %0d",
                     $time, tmr_stamps.size(), count);
        end
    endtask

    // Full periods of the reference clock, 8 system cycles per half period
    task automatic toggle_slow_clk(input int periods);
        repeat (periods) begin
            slow_clk = 1'b1;
            wait_cycles(8);
            slow_clk = 1'b0;
            wait_cycles(8);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_soc_ctrl();
        apb_data_t rdata;
        apb_data_t wdata;
        logic      err;
        check_eq("pready_o", 32'(pready), 32'd1);
        check_eq("pslverr_o", 32'(pslverr), 32'd0);
        check_eq("fc_events_o", fc_events, 32'd0);
        check_eq("gpio_dir_o", 32'(gpio_dir), 32'd0);
        check_eq("gpio_out_o", 32'(gpio_out), 32'd0);
        check_eq("fc_fetchen_o", 32'(fetchen), 32'd0);
        apb_read(reg_addr(REGION_SOC_CTRL, SOC_BOOTADDR), rdata, err);
        check_eq("SOC_BOOTADDR", rdata, BOOT_ADDR);
        wdata = $urandom;
        apb_write(reg_addr(REGION_SOC_CTRL, SOC_BOOTADDR), wdata, err);
        check_eq("fc_bootaddr_o", bootaddr, wdata);
        apb_read(reg_addr(REGION_SOC_CTRL, SOC_BOOTADDR), rdata, err);
        check_eq("SOC_BOOTADDR", rdata, wdata);
        wdata = $urandom;
        jtag_in = 8'(wdata >> 16);
        apb_write(reg_addr(REGION_SOC_CTRL, SOC_JTAG), wdata, err);
        check_eq("soc_jtag_reg_o", 32'(jtag_out), 32'(wdata[7:0]));
        apb_read(reg_addr(REGION_SOC_CTRL, SOC_JTAG), rdata, err);
        check_eq("SOC_JTAG", rdata, {16'h0000, jtag_in, wdata[7:0]});
        // Fetch enable pin override
        @(posedge clk);
        #1;
        fetch_en_valid = 1'b1;
        fetch_en       = 1'b1;
        wait_cycles(1);
        fetch_en_valid = 1'b0;
        fetch_en       = 1'b0;
        check_eq("fc_fetchen_o", 32'(fetchen), 32'd1);
        apb_read(reg_addr(REGION_SOC_CTRL, SOC_FETCHEN), rdata, err);
        check_eq("SOC_FETCHEN", rdata, 32'd1);
    endtask

    task automatic test_gpio_regs();
        apb_data_t rdata;
        apb_data_t dir_w;
        apb_data_t out_w;
        apb_data_t in_w;
        logic      err;
        dir_w = $urandom;
        out_w = $urandom;
        apb_write(reg_addr(REGION_GPIO, GPIO_DIR), dir_w, err);
        apb_write(reg_addr(REGION_GPIO, GPIO_OUT), out_w, err);
        check_eq("gpio_dir_o", 32'(gpio_dir), dir_w & GPIO_MASK);
        check_eq("gpio_out_o", 32'(gpio_out), out_w & GPIO_MASK);
        apb_read(reg_addr(REGION_GPIO, GPIO_DIR), rdata, err);
        check_eq("GPIO_DIR", rdata, dir_w & GPIO_MASK);
        in_w = $urandom;
        gpio_in = in_w[NGPIO-1:0];
        wait_cycles(3);
        apb_read(reg_addr(REGION_GPIO, GPIO_IN), rdata, err);
        check_eq("GPIO_IN", rdata, in_w & GPIO_MASK);
    endtask

    task automatic test_gpio_irq();
        apb_data_t   rdata;
        logic        err;
        int unsigned pin;
        int unsigned other;
        pin   = $urandom % NGPIO;
        other = (pin + 1) % NGPIO;
        gpio_in = '0;
        wait_cycles(4);
        apb_write(reg_addr(REGION_GPIO, GPIO_INTEN), 32'd1 << pin, err);
        apb_read(reg_addr(REGION_GPIO, GPIO_INTSTATUS), rdata, err);
        gpio_cnt = 0;
        // Disabled pin gives no event
        gpio_in[other] = 1'b1;
        wait_cycles(6);
        check_eq("gpio event count, disabled pin", gpio_cnt, 32'd0);
        gpio_in[pin] = 1'b1;
        wait_cycles(6);
        check_eq("gpio event count, enabled pin", gpio_cnt, 32'd1);
        apb_read(reg_addr(REGION_GPIO, GPIO_INTSTATUS), rdata, err);
        check_eq("GPIO_INTSTATUS", rdata, 32'd1 << pin);
        apb_read(reg_addr(REGION_GPIO, GPIO_INTSTATUS), rdata, err);
        check_eq("GPIO_INTSTATUS after read", rdata, 32'd0);
    endtask

    task automatic test_timer_clk();
        logic        err;
        int unsigned cmp;
        cmp = 3 + $urandom % 6;
        apb_write(reg_addr(REGION_TIMER, TMR_CMP), cmp, err);
        apb_write(reg_addr(REGION_TIMER, TMR_COUNT), 32'd0, err);
        apb_write(reg_addr(REGION_TIMER, TMR_CFG), 32'd1 << TMR_CFG_EN, err);
        tmr_stamps.delete();
        wait_timer_pulses(3, 4 * (cmp + 1));
        if (tmr_stamps.size() >= 3) begin
            check_eq("timer event interval", 32'(tmr_stamps[1] - tmr_stamps[0]), cmp + 1);
            check_eq("timer event interval", 32'(tmr_stamps[2] - tmr_stamps[1]), cmp + 1);
        end
        apb_write(reg_addr(REGION_TIMER, TMR_CFG), 32'd0, err);
    endtask

    task automatic test_ref_clk();
        logic err;
        apb_write(reg_addr(REGION_TIMER, TMR_CMP), 32'd2, err);
        apb_write(reg_addr(REGION_TIMER, TMR_COUNT), 32'd0, err);
        apb_write(reg_addr(REGION_TIMER, TMR_CFG),
                  (32'd1 << TMR_CFG_EN) | (32'd1 << TMR_CFG_REF), err);
        ref_cnt = 0;
        tmr_cnt = 0;
        // 6 periods, so 12 edge events and 2 timer events
        toggle_slow_clk(6);
        wait_cycles(6);
        check_eq("ref clock event count", ref_cnt, 32'd12);
        check_eq("timer event count, ref mode", tmr_cnt, 32'd2);
        apb_write(reg_addr(REGION_TIMER, TMR_CFG), 32'd0, err);
    endtask

    task automatic test_unmapped();
        apb_data_t rdata;
        logic      err;
        apb_read(12'h300, rdata, err);
        check_eq("pslverr_o, unmapped read", 32'(err), 32'd1);
        check_eq("prdata_o, unmapped read", rdata, 32'd0);
        apb_write(12'hF04, $urandom, err);
        check_eq("pslverr_o, unmapped write", 32'(err), 32'd1);
        apb_read(reg_addr(REGION_GPIO, GPIO_DIR), rdata, err);
        check_eq("pslverr_o, mapped read", 32'(err), 32'd0);
        check_eq("pready_o", 32'(pready), 32'd1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hc12b88f5));
        checks         = 0;
        errors         = 0;
        tmr_cnt        = 0;
        ref_cnt        = 0;
        gpio_cnt       = 0;
        rst_n          = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        pwrite         = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        slow_clk       = 1'b0;
        fetch_en_valid = 1'b0;
        fetch_en       = 1'b0;
        jtag_in        = '0;
        gpio_in        = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycles(1);

        test_soc_ctrl();
        test_gpio_regs();
        test_gpio_irq();
        test_timer_clk();
        test_ref_clk();
        test_unmapped();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: hw/apb_if.sv
// APB bus interface
// One master and one slave, zero wait state peripherals

`timescale 1ns/1ps

interface apb_if;
    import periph_pkg::*;

    apb_addr_t paddr;
    apb_data_t pwdata;
    logic      pwrite;
    logic      psel;
    logic      penable;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    modport master (
        output paddr, pwdata, pwrite, psel, penable,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  paddr, pwdata, pwrite, psel, penable,
        output prdata, pready, pslverr
    );

endinterface

// File: hw/apb_periph_decoder.sv
// APB peripheral decoder
// Splits one APB slave port over the SoC control, GPIO and timer
// buses by address region. Unmapped regions get an error response.

`timescale 1ns/1ps

module apb_periph_decoder (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  periph_pkg::apb_addr_t paddr_i,
    input  periph_pkg::apb_data_t pwdata_i,
    input  logic                  pwrite_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    output periph_pkg::apb_data_t prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    apb_if.master                 soc_bus,
    apb_if.master                 gpio_bus,
    apb_if.master                 tmr_bus
);
    import periph_pkg::*;

    region_e region;

    assign region = region_e'(paddr_i[11:8]);

    ////////////////////////////////////////////////////////////
    // Request fan-out
    ////////////////////////////////////////////////////////////

    assign soc_bus.paddr   = paddr_i;
    assign soc_bus.pwdata  = pwdata_i;
    assign soc_bus.pwrite  = pwrite_i;
    assign soc_bus.penable = penable_i;
    assign soc_bus.psel    = psel_i & (region == REGION_SOC_CTRL);

    assign gpio_bus.paddr   = paddr_i;
    assign gpio_bus.pwdata  = pwdata_i;
    assign gpio_bus.pwrite  = pwrite_i;
    assign gpio_bus.penable = penable_i;
    assign gpio_bus.psel    = psel_i & (region == REGION_GPIO);

    assign tmr_bus.paddr   = paddr_i;
    assign tmr_bus.pwdata  = pwdata_i;
    assign tmr_bus.pwrite  = pwrite_i;
    assign tmr_bus.penable = penable_i;
    assign tmr_bus.psel    = psel_i & (region == REGION_TIMER);

    ////////////////////////////////////////////////////////////
    // Response mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Unmapped region answers by itself, error only during a transfer
        prdata_o  = '0;
        pready_o  = 1'b1;
        pslverr_o = psel_i;
        case (region)
            REGION_SOC_CTRL: begin
                prdata_o  = soc_bus.prdata;
                pready_o  = soc_bus.pready;
                pslverr_o = soc_bus.pslverr;
            end
            REGION_GPIO: begin
                prdata_o  = gpio_bus.prdata;
                pready_o  = gpio_bus.pready;
                pslverr_o = gpio_bus.pslverr;
            end
            REGION_TIMER: begin
                prdata_o  = tmr_bus.prdata;
                pready_o  = tmr_bus.pready;
                pslverr_o = tmr_bus.pslverr;
            end
            default: ;
        endcase
    end

    // Never more than one peripheral selected
    a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({soc_bus.psel, gpio_bus.psel, tmr_bus.psel}));

endmodule

// File: hw/periph_event_map.sv
// Event mapping
// Synchronises the slow reference clock, turns its edges into pulses
// and packs the peripheral events into the FC event word

`timescale 1ns/1ps

module periph_event_map (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              slow_clk_i,
    input  logic                              gpio_event_i,
    input  logic                              timer_event_i,
    output logic                              ref_rise_o,
    output logic [periph_pkg::FC_EVENT_W-1:0] fc_events_o
);
    import periph_pkg::*;

    logic [2:0] ref_sync_q;
    logic       ref_fall_q;

    // Two sync stages, the third holds the previous level
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ref_sync_q <= '0;
            ref_rise_o <= 1'b0;
            ref_fall_q <= 1'b0;
        end else begin
            ref_sync_q <= {ref_sync_q[1:0], slow_clk_i};
            ref_rise_o <= ref_sync_q[1] & ~ref_sync_q[2];
            ref_fall_q <= ~ref_sync_q[1] & ref_sync_q[2];
        end
    end

    always_comb begin
        fc_events_o               = '0;
        fc_events_o[EVT_TIMER_LO] = timer_event_i;
        fc_events_o[EVT_REF_CLK]  = ref_rise_o | ref_fall_q;
        fc_events_o[EVT_GPIO]     = gpio_event_i;
    end

endmodule

// File: hw/periph_gpio.sv
// GPIO block
// Direction and output registers, two-flop input synchroniser and a
// rising-edge interrupt with a clear-on-read status register

`timescale 1ns/1ps

module periph_gpio #(
    parameter int unsigned NGPIO = 8
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    apb_if.slave             bus,
    input  logic [NGPIO-1:0] gpio_i,
    output logic [NGPIO-1:0] gpio_out_o,
    output logic [NGPIO-1:0] gpio_dir_o,
    output logic             gpio_event_o
);
    import periph_pkg::*;

    logic [7:0]       reg_addr;
    logic             wr_en;
    logic             rd_status;
    logic [NGPIO-1:0] sync_q1;
    logic [NGPIO-1:0] sync_q2;
    logic [NGPIO-1:0] prev_q;
    logic [NGPIO-1:0] inten_q;
    logic [NGPIO-1:0] status_q;
    logic [NGPIO-1:0] rise;

    assign reg_addr  = bus.paddr[7:0];
    assign wr_en     = bus.psel & bus.penable & bus.pwrite;
    assign rd_status = bus.psel & bus.penable & ~bus.pwrite & (reg_addr == GPIO_INTSTATUS);

    // Enabled pins that just went high
    assign rise = sync_q2 & ~prev_q & inten_q;

    ////////////////////////////////////////////////////////////
    // Input synchroniser and edge detection
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q1      <= '0;
            sync_q2      <= '0;
            prev_q       <= '0;
            status_q     <= '0;
            gpio_event_o <= 1'b0;
        end else begin
            sync_q1 <= gpio_i;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
            // New edges survive a status read in the same cycle
            if (rd_status) begin
                status_q <= rise;
            end else begin
                status_q <= status_q | rise;
            end
            gpio_event_o <= |rise;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gpio_dir_o <= '0;
            gpio_out_o <= '0;
            inten_q    <= '0;
        end else if (wr_en) begin
            case (reg_addr)
                GPIO_DIR:   gpio_dir_o <= bus.pwdata[NGPIO-1:0];
                GPIO_OUT:   gpio_out_o <= bus.pwdata[NGPIO-1:0];
                GPIO_INTEN: inten_q    <= bus.pwdata[NGPIO-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_addr)
            GPIO_DIR:       bus.prdata = apb_data_t'(gpio_dir_o);
            GPIO_OUT:       bus.prdata = apb_data_t'(gpio_out_o);
            GPIO_IN:        bus.prdata = apb_data_t'(sync_q2);
            GPIO_INTEN:     bus.prdata = apb_data_t'(inten_q);
            GPIO_INTSTATUS: bus.prdata = apb_data_t'(status_q);
            default:        bus.prdata = '0;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    a_event_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        gpio_event_o |=> !gpio_event_o);

endmodule

// File: hw/periph_pkg.sv
// Peripheral subsystem package
// Bus widths, the address map, register offsets and the bit
// positions of the fabric controller event word

package periph_pkg;

    // APB bus widths
    localparam int unsigned APB_ADDR_W = 12;
    localparam int unsigned APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // Peripheral selected by address bits 11 to 8
    typedef enum logic [3:0] {
        REGION_SOC_CTRL = 4'd0,
        REGION_GPIO     = 4'd1,
        REGION_TIMER    = 4'd2
    } region_e;

    // SoC control register offsets
    localparam logic [7:0] SOC_BOOTADDR = 8'h00;
    localparam logic [7:0] SOC_FETCHEN  = 8'h04;
    localparam logic [7:0] SOC_JTAG     = 8'h08;

    // GPIO register offsets
    localparam logic [7:0] GPIO_DIR       = 8'h00;
    localparam logic [7:0] GPIO_OUT       = 8'h04;
    localparam logic [7:0] GPIO_IN        = 8'h08;
    localparam logic [7:0] GPIO_INTEN     = 8'h0C;
    localparam logic [7:0] GPIO_INTSTATUS = 8'h10;

    // Timer register offsets and config bits
    localparam logic [7:0] TMR_CFG   = 8'h00;
    localparam logic [7:0] TMR_COUNT = 8'h04;
    localparam logic [7:0] TMR_CMP   = 8'h08;
    localparam int unsigned TMR_CFG_EN  = 0;
    localparam int unsigned TMR_CFG_REF = 1;

    // Fabric controller event word
    localparam int unsigned FC_EVENT_W   = 32;
    localparam int unsigned EVT_TIMER_LO = 10;
    localparam int unsigned EVT_REF_CLK  = 14;
    localparam int unsigned EVT_GPIO     = 15;

endpackage

// File: hw/periph_soc_ctrl.sv
// SoC control registers
// Boot address and fetch enable for the fabric controller, plus the
// 8-bit exchange register shared with the JTAG TAP

`timescale 1ns/1ps

module periph_soc_ctrl #(
    parameter periph_pkg::apb_data_t BOOT_ADDR_DEFAULT = 32'h1C00_8080
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    apb_if.slave                  bus,
    input  logic                  fc_fetch_en_valid_i,
    input  logic                  fc_fetch_en_i,
    input  logic [7:0]            soc_jtag_reg_i,
    output periph_pkg::apb_data_t fc_bootaddr_o,
    output logic                  fc_fetchen_o,
    output logic [7:0]            soc_jtag_reg_o
);
    import periph_pkg::*;

    logic       wr_en;
    logic [7:0] reg_addr;

    assign reg_addr = bus.paddr[7:0];
    assign wr_en    = bus.psel & bus.penable & bus.pwrite;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fc_bootaddr_o  <= BOOT_ADDR_DEFAULT;
            fc_fetchen_o   <= 1'b0;
            soc_jtag_reg_o <= '0;
        end else begin
            if (wr_en && reg_addr == SOC_BOOTADDR) begin
                fc_bootaddr_o <= bus.pwdata;
            end
            // Pin override beats a bus write
            if (fc_fetch_en_valid_i) begin
                fc_fetchen_o <= fc_fetch_en_i;
            end else if (wr_en && reg_addr == SOC_FETCHEN) begin
                fc_fetchen_o <= bus.pwdata[0];
            end
            if (wr_en && reg_addr == SOC_JTAG) begin
                soc_jtag_reg_o <= bus.pwdata[7:0];
            end
        end
    end

    always_comb begin
        case (reg_addr)
            SOC_BOOTADDR: bus.prdata = fc_bootaddr_o;
            SOC_FETCHEN:  bus.prdata = apb_data_t'(fc_fetchen_o);
            SOC_JTAG:     bus.prdata = {16'h0000, soc_jtag_reg_i, soc_jtag_reg_o};
            default:      bus.prdata = '0;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

endmodule

// File: hw/periph_timer.sv
// Compare timer
// One 32-bit counter with a compare channel. Ticks are system clock
// cycles or rising edges of the reference clock.

`timescale 1ns/1ps

module periph_timer (
    input  logic  clk_i,
    input  logic  rst_ni,
    apb_if.slave  bus,
    input  logic  ref_rise_i,
    output logic  timer_event_o
);
    import periph_pkg::*;

    logic [7:0] reg_addr;
    logic       wr_en;
    logic [1:0] cfg_q;
    apb_data_t  count_q;
    apb_data_t  cmp_q;
    logic       tick;
    logic       match;

    assign reg_addr = bus.paddr[7:0];
    assign wr_en    = bus.psel & bus.penable & bus.pwrite;

    // Tick source selected by the REF bit
    assign tick  = cfg_q[TMR_CFG_EN] & (cfg_q[TMR_CFG_REF] ? ref_rise_i : 1'b1);
    assign match = (count_q == cmp_q);

    ////////////////////////////////////////////////////////////
    // Config and compare registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;
            cmp_q <= '0;
        end else if (wr_en) begin
            if (reg_addr == TMR_CFG) begin
                cfg_q <= bus.pwdata[1:0];
            end
            if (reg_addr == TMR_CMP) begin
                cmp_q <= bus.pwdata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Counter and compare event
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q       <= '0;
            timer_event_o <= 1'b0;
        end else begin
            // Software load wins over a tick
            if (wr_en && reg_addr == TMR_COUNT) begin
                count_q <= bus.pwdata;
            end else if (tick) begin
                count_q <= match ? '0 : count_q + 1'b1;
            end
            timer_event_o <= tick & match;
        end
    end

    always_comb begin
        case (reg_addr)
            TMR_CFG:   bus.prdata = apb_data_t'(cfg_q);
            TMR_COUNT: bus.prdata = count_q;
            TMR_CMP:   bus.prdata = cmp_q;
            default:   bus.prdata = '0;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    // A compare of zero in clock mode fires every cycle
    a_event_width: assert property (@(posedge clk_i) disable iff (!rst_ni)
        timer_event_o && (cmp_q != '0) |=> !timer_event_o);

endmodule

// File: hw/soc_periph_top.sv
// SoC peripheral subsystem
// APB slave port decoded over SoC control, GPIO and timer, with the
// reference clock event logic feeding the FC event word

`timescale 1ns/1ps

module soc_periph_top #(
    parameter int unsigned           NGPIO             = 8,
    parameter periph_pkg::apb_data_t BOOT_ADDR_DEFAULT = 32'h1C00_8080
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  periph_pkg::apb_addr_t             paddr_i,
    input  periph_pkg::apb_data_t             pwdata_i,
    input  logic                              pwrite_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    output periph_pkg::apb_data_t             prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    input  logic                              slow_clk_i,
    input  logic                              fc_fetch_en_valid_i,
    input  logic                              fc_fetch_en_i,
    input  logic [7:0]                        soc_jtag_reg_i,
    output logic [7:0]                        soc_jtag_reg_o,
    input  logic [NGPIO-1:0]                  gpio_i,
    output logic [NGPIO-1:0]                  gpio_out_o,
    output logic [NGPIO-1:0]                  gpio_dir_o,
    output periph_pkg::apb_data_t             fc_bootaddr_o,
    output logic                              fc_fetchen_o,
    output logic [periph_pkg::FC_EVENT_W-1:0] fc_events_o
);

    apb_if soc_bus ();
    apb_if gpio_bus ();
    apb_if tmr_bus ();

    logic ref_rise;
    logic gpio_event;
    logic timer_event;

    ////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////

    apb_periph_decoder i_decoder (
        .clk_i     ( clk_i     ),
        .rst_ni    ( rst_ni    ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .pwrite_i  ( pwrite_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .soc_bus   ( soc_bus   ),
        .gpio_bus  ( gpio_bus  ),
        .tmr_bus   ( tmr_bus   )
    );

    ////////////////////////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////////////////////////

    periph_soc_ctrl #(
        .BOOT_ADDR_DEFAULT ( BOOT_ADDR_DEFAULT )
    ) i_soc_ctrl (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .bus                 ( soc_bus             ),
        .fc_fetch_en_valid_i ( fc_fetch_en_valid_i ),
        .fc_fetch_en_i       ( fc_fetch_en_i       ),
        .soc_jtag_reg_i      ( soc_jtag_reg_i      ),
        .fc_bootaddr_o       ( fc_bootaddr_o       ),
        .fc_fetchen_o        ( fc_fetchen_o        ),
        .soc_jtag_reg_o      ( soc_jtag_reg_o      )
    );

    periph_gpio #(
        .NGPIO ( NGPIO )
    ) i_gpio (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .bus          ( gpio_bus   ),
        .gpio_i       ( gpio_i     ),
        .gpio_out_o   ( gpio_out_o ),
        .gpio_dir_o   ( gpio_dir_o ),
        .gpio_event_o ( gpio_event )
    );

    periph_timer i_timer (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .bus           ( tmr_bus     ),
        .ref_rise_i    ( ref_rise    ),
        .timer_event_o ( timer_event )
    );

    periph_event_map i_event_map (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .slow_clk_i    ( slow_clk_i  ),
        .gpio_event_i  ( gpio_event  ),
        .timer_event_i ( timer_event ),
        .ref_rise_o    ( ref_rise    ),
        .fc_events_o   ( fc_events_o )
    );

endmodule
